// ==== sim.f ====
vxe_hub_pkg.sv
rsp_fifo.sv
ds_rx_merge.sv
ds_tx_drain.sv
vpu_ds_hub.sv
tb_vpu_ds_hub.sv

// ==== Bender.yml ====
package:
  name: vpu_ds_hub

sources:
  - vxe_hub_pkg.sv
  - rsp_fifo.sv
  - ds_rx_merge.sv
  - ds_tx_drain.sv
  - vpu_ds_hub.sv
  - target: test
    files:
      - tb_vpu_ds_hub.sv

// ==== tb_vpu_ds_hub.sv ====
// Directed testbench of the downstream hub. Master 0 uses ids 0 to 31, master 1 uses 32 to 63.
// Read data is a pattern of the id, so every data word can be traced back to its status.
`timescale 1ns/1ps
`default_nettype none

module tb_vpu_ds_hub;

	localparam int CLK_PERIOD = 8;
	localparam int N_BURST = 8;	// Writes in the error code burst.
	localparam int N_ALT = 10;	// Words per master in the alternation test.
	localparam int N_HOLD = 6;	// Master 1 words that pass a stuck read.
	localparam int N_RAND = 24;	// Words per master under back-pressure.
	// A status and at most one data word per transaction, over all tests.
	localparam int TOTAL_WORDS = 2 * (1 + N_BURST + 2 * N_ALT + 1 + N_HOLD + 2 * N_RAND);
	localparam int TIMEOUT_NS = TOTAL_WORDS * 40 * CLK_PERIOD;

	logic clk;
	logic nrst;
	logic i_m0_rss_vld, i_m0_rsd_vld, i_m1_rss_vld, i_m1_rsd_vld;
	logic [vxe_hub_pkg::RSS_W-1:0] i_m0_rss, i_m1_rss;
	logic [vxe_hub_pkg::RSD_W-1:0] i_m0_rsd, i_m1_rsd;
	logic o_m0_rss_rd, o_m0_rsd_rd, o_m1_rss_rd, o_m1_rsd_rd;
	logic i_rss_rdy, i_rsd_rdy;
	logic [vxe_hub_pkg::RSS_W-1:0] o_rss;
	logic [vxe_hub_pkg::RSD_W-1:0] o_rsd;
	logic o_rss_wr, o_rsd_wr;

	// Words still to be offered by each master model.
	logic [vxe_hub_pkg::RSS_W-1:0] m0_rss_q [$];
	logic [vxe_hub_pkg::RSS_W-1:0] m1_rss_q [$];
	logic [vxe_hub_pkg::RSD_W-1:0] m0_rsd_q [$];
	logic [vxe_hub_pkg::RSD_W-1:0] m1_rsd_q [$];
	// Scoreboards. Statuses are expected in order per master.
	logic [vxe_hub_pkg::RSS_W-1:0] exp_m0_q [$];
	logic [vxe_hub_pkg::RSS_W-1:0] exp_m1_q [$];
	logic [5:0] read_order_q [$];			// Read ids in output status order.
	logic [vxe_hub_pkg::RSD_W-1:0] got_rsd_q [$];	// Data words not yet matched.

	logic hold0;		// Master 0 withholds its read data.
	logic rand_rdy;		// Client ready is random.
	logic no_data;		// No data word may appear.
	logic check_alt;	// Output statuses must alternate masters.
	logic have_prev, prev_src;
	logic take0, take1, dtake0, dtake1;
	logic rss_held, rsd_held;
	logic [vxe_hub_pkg::RSS_W-1:0] rss_last;
	logic [vxe_hub_pkg::RSD_W-1:0] rsd_last;
	int next_id0, next_id1;
	string test_name;

	vpu_ds_hub vpu_ds_hub_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	// The id sits in 8:3, the read flag in 2 and the error code in 1:0.
	function automatic logic [vxe_hub_pkg::RSS_W-1:0] make_rss(input logic [5:0] id,
		input logic rnw, input logic [1:0] err);
		return {id, rnw, err};
	endfunction

	// Every bit of the id shows up in several places of the word.
	function automatic logic [vxe_hub_pkg::RSD_W-1:0] data_pattern(input logic [5:0] id);
		return {16'hc0de, 2'b00, id, ~id, 2'b11, {4{id, 2'b01}}};
	endfunction

	// Queues one transaction on a master and on the scoreboard.
	task automatic issue(input logic from_m1, input logic rnw, input logic [1:0] err);
		logic [5:0] id;
		logic [vxe_hub_pkg::RSS_W-1:0] word;
		id = from_m1 ? (6'd32 | 6'(next_id1 % 32)) : 6'(next_id0 % 32);
		word = make_rss(id, rnw, err);
		if (from_m1)
		begin
			next_id1++;
			m1_rss_q.push_back(word);
			exp_m1_q.push_back(word);
			if (rnw)
				m1_rsd_q.push_back(data_pattern(id));
		end
		else
		begin
			next_id0++;
			m0_rss_q.push_back(word);
			exp_m0_q.push_back(word);
			if (rnw)
				m0_rsd_q.push_back(data_pattern(id));
		end
	endtask

	// An accepted status must be the oldest outstanding one of its master.
	task automatic check_status(input logic [vxe_hub_pkg::RSS_W-1:0] word);
		logic [5:0] id;
		logic src;
		logic [vxe_hub_pkg::RSS_W-1:0] exp_word;
		id = word[vxe_hub_pkg::TXNID_MSB:vxe_hub_pkg::TXNID_LSB];
		src = id[5];	// Ids from 32 up belong to master 1.
		if (src)
		begin
			assert (exp_m1_q.size() != 0)
			else fail_run("a master 1 status appeared with none outstanding");
			exp_word = exp_m1_q.pop_front();
		end
		else
		begin
			assert (exp_m0_q.size() != 0)
			else fail_run("a master 0 status appeared with none outstanding");
			exp_word = exp_m0_q.pop_front();
		end
		assert (word == exp_word)
		else fail_run($sformatf("ERR %s expected %h actual %h", test_name, exp_word, word));
		if (check_alt && have_prev)
			assert (src != prev_src)
			else fail_run($sformatf("ERR %s expected %0d actual %0d", test_name, !prev_src, src));
		have_prev = 1'b1;
		prev_src = src;
		if (word[vxe_hub_pkg::RNW_BIT])
			read_order_q.push_back(id);
	endtask

	// Data words pair up with read statuses in output order.
	task automatic match_data();
		logic [5:0] id;
		logic [vxe_hub_pkg::RSD_W-1:0] got;
		while (read_order_q.size() != 0 && got_rsd_q.size() != 0)
		begin
			id = read_order_q.pop_front();
			got = got_rsd_q.pop_front();
			assert (got == data_pattern(id))
			else fail_run($sformatf("ERR %s expected %h actual %h", test_name,
				data_pattern(id), got));
		end
	endtask

	// Returns once every issued word has left the hub.
	task automatic wait_drained();
		do
		begin
			@(negedge clk);
			#1;
		end
		while (m0_rss_q.size() != 0 || m1_rss_q.size() != 0 || m0_rsd_q.size() != 0 ||
			m1_rsd_q.size() != 0 || exp_m0_q.size() != 0 || exp_m1_q.size() != 0 ||
			o_rss_wr || o_rsd_wr);
		@(negedge clk);
		#1;
		assert (read_order_q.size() == 0) else fail_run("a read status came out without data");
		assert (got_rsd_q.size() == 0) else fail_run("a data word came out without a read");
	endtask

	// --------------------------------------------------
	// Master and client models
	// --------------------------------------------------

	// Handshakes are sampled at the falling edge, where rd and vld are settled.
	always
	begin
		@(negedge clk);
		take0 = i_m0_rss_vld && o_m0_rss_rd;
		take1 = i_m1_rss_vld && o_m1_rss_rd;
		dtake0 = i_m0_rsd_vld && o_m0_rsd_rd;
		dtake1 = i_m1_rsd_vld && o_m1_rsd_rd;
		@(posedge clk);
		#1;
		if (take0)
			m0_rss_q.delete(0);
		if (take1)
			m1_rss_q.delete(0);
		if (dtake0)
			m0_rsd_q.delete(0);
		if (dtake1)
			m1_rsd_q.delete(0);
		i_m0_rss_vld = (m0_rss_q.size() != 0);	// Held until taken.
		i_m1_rss_vld = (m1_rss_q.size() != 0);
		i_m0_rsd_vld = !hold0 && (m0_rsd_q.size() != 0);
		i_m1_rsd_vld = (m1_rsd_q.size() != 0);
		if (i_m0_rss_vld)
			i_m0_rss = m0_rss_q[0];
		if (i_m1_rss_vld)
			i_m1_rss = m1_rss_q[0];
		if (m0_rsd_q.size() != 0)
			i_m0_rsd = m0_rsd_q[0];
		if (i_m1_rsd_vld)
			i_m1_rsd = m1_rsd_q[0];
		i_rss_rdy = rand_rdy ? 1'($urandom % 2) : 1'b1;
		i_rsd_rdy = rand_rdy ? 1'($urandom % 2) : 1'b1;
	end

	// Output monitor. A word with wr and rdy high here is accepted at the next edge.
	always
	begin
		@(negedge clk);
		if (nrst)
		begin
			if (rss_held)
			begin
				assert (o_rss_wr) else fail_run("a status was withdrawn before it was accepted");
				assert (o_rss == rss_last)
				else fail_run($sformatf("ERR %s expected %h actual %h", test_name, rss_last, o_rss));
			end
			if (rsd_held)
			begin
				assert (o_rsd_wr) else fail_run("a data word was withdrawn before it was accepted");
				assert (o_rsd == rsd_last)
				else fail_run($sformatf("ERR %s expected %h actual %h", test_name, rsd_last, o_rsd));
			end
			rss_held = o_rss_wr && !i_rss_rdy;
			rsd_held = o_rsd_wr && !i_rsd_rdy;
			rss_last = o_rss;
			rsd_last = o_rsd;
			if (no_data)
				assert (!o_rsd_wr) else fail_run("a data word appeared during a write burst");
			// A read whose data is withheld must stay with the master.
			if (hold0 && m0_rss_q.size() != 0 && m0_rss_q[0][vxe_hub_pkg::RNW_BIT])
				assert (!o_m0_rss_rd) else fail_run("a read status was taken without its data");
			if (o_rss_wr && i_rss_rdy)
				check_status(o_rss);
			if (o_rsd_wr && i_rsd_rdy)
				got_rsd_q.push_back(o_rsd);
			match_data();
		end
		else
		begin
			rss_held = 1'b0;
			rsd_held = 1'b0;
		end
	end

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------

	task automatic single_read_after_reset();
		test_name = "single_read_after_reset";
		@(negedge clk);
		assert (!o_m0_rss_rd && !o_m0_rsd_rd && !o_m1_rss_rd && !o_m1_rsd_rd)
		else fail_run("a master read strobe is high after reset");
		assert (!o_rss_wr && !o_rsd_wr) else fail_run("an output write is high after reset");
		issue(1'b0, 1'b1, 2'b00);
		wait_drained();
	endtask

	task automatic write_burst_errors();
		test_name = "write_burst_errors";
		no_data = 1'b1;
		for (int i = 0; i < N_BURST; i++)
			issue(1'b1, 1'b0, 2'(i));	// Every error code comes through.
		wait_drained();
		no_data = 1'b0;
	endtask

	task automatic both_masters_alternate();
		test_name = "both_masters_alternate";
		check_alt = 1'b1;
		have_prev = 1'b0;
		for (int i = 0; i < N_ALT; i++)
		begin
			issue(1'b0, 1'(i), 2'(i));
			issue(1'b1, !1'(i), 2'(i + 1));
		end
		wait_drained();
		check_alt = 1'b0;
	endtask

	task automatic withheld_read_data();
		test_name = "withheld_read_data";
		hold0 = 1'b1;
		issue(1'b0, 1'b1, 2'b01);
		for (int i = 0; i < N_HOLD; i++)
			issue(1'b1, 1'(i), 2'(i));
		while (exp_m1_q.size() != 0)
		begin
			@(negedge clk);
			#1;
		end
		assert (m0_rss_q.size() == 1 && exp_m0_q.size() == 1)
		else fail_run("the read with withheld data left master 0");
		hold0 = 1'b0;
		wait_drained();
	endtask

	task automatic random_backpressure();
		test_name = "random_backpressure";
		rand_rdy = 1'b1;
		for (int i = 0; i < N_RAND; i++)
		begin
			issue(1'b0, 1'($urandom % 2), 2'($urandom % 4));
			issue(1'b1, 1'($urandom % 2), 2'($urandom % 4));
		end
		wait_drained();
		rand_rdy = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h3c2f));
		{hold0, rand_rdy, no_data, check_alt, have_prev, prev_src} = '0;
		{rss_held, rsd_held, next_id0, next_id1} = '0;
		{i_m0_rss_vld, i_m0_rsd_vld, i_m1_rss_vld, i_m1_rsd_vld} = '0;
		{i_m0_rss, i_m1_rss, i_m0_rsd, i_m1_rsd} = '0;
		i_rss_rdy = 1'b1;
		i_rsd_rdy = 1'b1;
		nrst = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		nrst = 1'b1;
		single_read_after_reset();
		write_burst_errors();
		both_masters_alternate();
		withheld_read_data();
		random_backpressure();
		$display("test passed");
		$finish;
	end

	// Stops a run in which the hub no longer moves words.
	initial
	begin
		#(TIMEOUT_NS);
		fail_run($sformatf("timeout after %0d ns, the hub stopped moving words", TIMEOUT_NS));
	end

endmodule

`default_nettype wire

// ==== vpu_ds_hub.sv ====
// Downstream response hub of the vector unit. Two masters merge into one status stream
// and one data stream. Read data leaves in the same order as the read statuses.
`timescale 1ns/1ps
`default_nettype none

module vpu_ds_hub
(
	input wire				clk,
	input wire				nrst,
	// Incoming responses on master 0.
	input wire				i_m0_rss_vld,
	input wire [vxe_hub_pkg::RSS_W-1:0]	i_m0_rss,
	output logic				o_m0_rss_rd,
	input wire				i_m0_rsd_vld,
	input wire [vxe_hub_pkg::RSD_W-1:0]	i_m0_rsd,
	output logic				o_m0_rsd_rd,
	// Incoming responses on master 1.
	input wire				i_m1_rss_vld,
	input wire [vxe_hub_pkg::RSS_W-1:0]	i_m1_rss,
	output logic				o_m1_rss_rd,
	input wire				i_m1_rsd_vld,
	input wire [vxe_hub_pkg::RSD_W-1:0]	i_m1_rsd,
	output logic				o_m1_rsd_rd,
	// Outgoing responses to the vector unit.
	input wire				i_rss_rdy,
	output logic [vxe_hub_pkg::RSS_W-1:0]	o_rss,
	output logic				o_rss_wr,
	input wire				i_rsd_rdy,
	output logic [vxe_hub_pkg::RSD_W-1:0]	o_rsd,
	output logic				o_rsd_wr
);

	// --------------------------------------------------
	// Internal streams
	// --------------------------------------------------

	// Status stream between merger, FIFO and drain.
	logic				rss_push;
	logic [vxe_hub_pkg::RSS_W-1:0]	rss_wdata;
	logic				rss_pop;
	logic [vxe_hub_pkg::RSS_W-1:0]	rss_rdata;
	logic				rss_empty;
	logic				rss_full;
	logic				rss_afull;

	// Data stream between merger, FIFO and drain.
	logic				rsd_push;
	logic [vxe_hub_pkg::RSD_W-1:0]	rsd_wdata;
	logic				rsd_pop;
	logic [vxe_hub_pkg::RSD_W-1:0]	rsd_rdata;
	logic				rsd_empty;
	logic				rsd_full;
	logic				rsd_afull;

	// The data stream has its own ready, so it can back up while statuses still flow.
	// Its flags join the stall so that neither FIFO can overflow.
	ds_rx_merge merge_i (
		.clk		(clk),
		.nrst		(nrst),
		.i_m0_rss_vld	(i_m0_rss_vld),
		.i_m0_rss	(i_m0_rss),
		.o_m0_rss_rd	(o_m0_rss_rd),
		.i_m0_rsd_vld	(i_m0_rsd_vld),
		.i_m0_rsd	(i_m0_rsd),
		.o_m0_rsd_rd	(o_m0_rsd_rd),
		.i_m1_rss_vld	(i_m1_rss_vld),
		.i_m1_rss	(i_m1_rss),
		.o_m1_rss_rd	(o_m1_rss_rd),
		.i_m1_rsd_vld	(i_m1_rsd_vld),
		.i_m1_rsd	(i_m1_rsd),
		.o_m1_rsd_rd	(o_m1_rsd_rd),
		.i_rss_full	(rss_full | rsd_full),
		.i_rss_afull	(rss_afull | rsd_afull),
		.o_rss_push	(rss_push),
		.o_rss_wdata	(rss_wdata),
		.o_rsd_push	(rsd_push),
		.o_rsd_wdata	(rsd_wdata)
	);

	rsp_fifo #(.WIDTH(vxe_hub_pkg::RSS_W)) rss_fifo_i (
		.clk(clk), .nrst(nrst), .i_push(rss_push), .i_wdata(rss_wdata),
		.i_pop(rss_pop), .o_rdata(rss_rdata), .o_empty(rss_empty),
		.o_full(rss_full), .o_afull(rss_afull)
	);

	rsp_fifo #(.WIDTH(vxe_hub_pkg::RSD_W)) rsd_fifo_i (
		.clk(clk), .nrst(nrst), .i_push(rsd_push), .i_wdata(rsd_wdata),
		.i_pop(rsd_pop), .o_rdata(rsd_rdata), .o_empty(rsd_empty),
		.o_full(rsd_full), .o_afull(rsd_afull)
	);

	ds_tx_drain #(.WIDTH(vxe_hub_pkg::RSS_W)) rss_drain_i (
		.clk(clk), .nrst(nrst), .i_empty(rss_empty), .i_rdata(rss_rdata),
		.o_pop(rss_pop), .i_rdy(i_rss_rdy), .o_word(o_rss), .o_wr(o_rss_wr)
	);

	ds_tx_drain #(.WIDTH(vxe_hub_pkg::RSD_W)) rsd_drain_i (
		.clk(clk), .nrst(nrst), .i_empty(rsd_empty), .i_rdata(rsd_rdata),
		.o_pop(rsd_pop), .i_rdy(i_rsd_rdy), .o_word(o_rsd), .o_wr(o_rsd_wr)
	);

endmodule

`default_nettype wire

// ==== ds_tx_drain.sv ====
// Moves FIFO words to a write/ready client through a registered output.
// The word is held while the client is not ready, nothing is dropped.
`timescale 1ns/1ps
`default_nettype none

module ds_tx_drain
#(
	parameter int WIDTH = 8		// Word width.
)
(
	input wire			clk,
	input wire			nrst,
	input wire			i_empty,	// FIFO has no word.
	input wire [WIDTH-1:0]		i_rdata,	// FIFO head word.
	output logic			o_pop,		// Takes the FIFO head.
	input wire			i_rdy,		// Client accepts the output word.
	output logic [WIDTH-1:0]	o_word,		// Word to the client.
	output logic			o_wr		// Output word is valid.
);

	logic	tx_state;	// Idle or sending.
	logic	load;		// Output register takes the head this edge.

	// The register loads when it is empty or being accepted, and the FIFO has a word.
	assign load = !i_empty && ((tx_state == vxe_hub_pkg::TX_IDLE) || i_rdy);
	assign o_pop = load;	// Every load consumes the head.

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			tx_state <= vxe_hub_pkg::TX_IDLE;
		else if (load)
			tx_state <= vxe_hub_pkg::TX_SEND;	// A fresh word is on the output.
		else if (i_rdy)
			tx_state <= vxe_hub_pkg::TX_IDLE;	// Last word accepted, FIFO is dry.
	end

	// Payload register. It only changes on a load.
	always_ff @(posedge clk)
	begin
		if (load)
			o_word <= i_rdata;
	end

	assign o_wr = (tx_state == vxe_hub_pkg::TX_SEND);	// Comes straight from the state flop.

	// A word that is not accepted stays on the output unchanged.
	a_hold_word: assert property (@(posedge clk) disable iff (!nrst)
		o_wr && !i_rdy |=> o_wr && $stable(o_word));

endmodule

`default_nettype wire

// ==== ds_rx_merge.sv ====
// Round-robin merger of two response masters. A read status is taken only with its data.
// The stall inputs must rise before the FIFOs behind them can overflow.
`timescale 1ns/1ps
`default_nettype none

module ds_rx_merge
(
	input wire				clk,
	input wire				nrst,
	// Master 0 status and data channels.
	input wire				i_m0_rss_vld,
	input wire [vxe_hub_pkg::RSS_W-1:0]	i_m0_rss,
	output logic				o_m0_rss_rd,
	input wire				i_m0_rsd_vld,
	input wire [vxe_hub_pkg::RSD_W-1:0]	i_m0_rsd,
	output logic				o_m0_rsd_rd,
	// Master 1 status and data channels.
	input wire				i_m1_rss_vld,
	input wire [vxe_hub_pkg::RSS_W-1:0]	i_m1_rss,
	output logic				o_m1_rss_rd,
	input wire				i_m1_rsd_vld,
	input wire [vxe_hub_pkg::RSD_W-1:0]	i_m1_rsd,
	output logic				o_m1_rsd_rd,
	// Stall indications from the FIFOs.
	input wire				i_rss_full,
	input wire				i_rss_afull,
	// Writes into the status and data FIFOs.
	output logic				o_rss_push,
	output logic [vxe_hub_pkg::RSS_W-1:0]	o_rss_wdata,
	output logic				o_rsd_push,
	output logic [vxe_hub_pkg::RSD_W-1:0]	o_rsd_wdata
);

	logic [1:0]	rx_state;	// Current grant, or idle, or stall.
	logic [1:0]	rx_next;	// State for the next cycle.
	logic		last_m1_q;	// Master that held the grant last.
	logic		last_m1;	// Grant in effect, as seen by the round robin.
	logic		stall;		// No room for another word.
	logic		m0_rnw;		// Master 0 status is a read.
	logic		m1_rnw;		// Master 1 status is a read.
	logic		m0_take;	// Master 0 status is consumed this edge.
	logic		m1_take;	// Master 1 status is consumed this edge.

	// One free entry is kept as slack, so almost full stalls as well.
	assign stall = i_rss_full | i_rss_afull;

	// The read flag is the only field the merger looks at.
	assign m0_rnw = i_m0_rss[vxe_hub_pkg::RNW_BIT];
	assign m1_rnw = i_m1_rss[vxe_hub_pkg::RNW_BIT];

	// --------------------------------------------------
	// Consumption
	// --------------------------------------------------

	// A granted status is taken when it is valid and there is room.
	// A read also needs its data word, otherwise both wait.
	assign m0_take = (rx_state == vxe_hub_pkg::RX_M0) && !stall && i_m0_rss_vld &&
		(!m0_rnw || i_m0_rsd_vld);
	assign m1_take = (rx_state == vxe_hub_pkg::RX_M1) && !stall && i_m1_rss_vld &&
		(!m1_rnw || i_m1_rsd_vld);

	assign o_m0_rss_rd = m0_take;
	assign o_m1_rss_rd = m1_take;

	// Data is pulled only together with its read status.
	assign o_m0_rsd_rd = m0_take & m0_rnw;
	assign o_m1_rsd_rd = m1_take & m1_rnw;

	// The consumed words go straight into the FIFOs in the same edge.
	assign o_rss_push = m0_take | m1_take;
	assign o_rss_wdata = m1_take ? i_m1_rss : i_m0_rss;
	assign o_rsd_push = o_m0_rsd_rd | o_m1_rsd_rd;
	assign o_rsd_wdata = o_m1_rsd_rd ? i_m1_rsd : i_m0_rsd;

	// --------------------------------------------------
	// Round-robin grant
	// --------------------------------------------------

	// While a master holds the grant it is the last one. Idle and stall keep the stored one.
	always_comb
	begin
		case (rx_state)
			vxe_hub_pkg::RX_M0: last_m1 = 1'b0;
			vxe_hub_pkg::RX_M1: last_m1 = 1'b1;
			default: last_m1 = last_m1_q;
		endcase
	end

	// The other master wins whenever it is valid. The same master keeps the grant
	// only when the other one has nothing, which also covers a read waiting for data.
	always_comb
	begin
		if (stall)
			rx_next = vxe_hub_pkg::RX_STALL;	// Pause until the FIFO drains.
		else if (last_m1)
		begin
			if (i_m0_rss_vld)
				rx_next = vxe_hub_pkg::RX_M0;
			else if (i_m1_rss_vld)
				rx_next = vxe_hub_pkg::RX_M1;
			else
				rx_next = vxe_hub_pkg::RX_IDLE;
		end
		else
		begin
			if (i_m1_rss_vld)
				rx_next = vxe_hub_pkg::RX_M1;
			else if (i_m0_rss_vld)
				rx_next = vxe_hub_pkg::RX_M0;
			else
				rx_next = vxe_hub_pkg::RX_IDLE;
		end
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			rx_state <= vxe_hub_pkg::RX_IDLE;	// No grant, so every rd is low.
			last_m1_q <= 1'b1;			// Master 0 goes first after reset.
		end
		else
		begin
			rx_state <= rx_next;
			last_m1_q <= last_m1;	// Survives idle and stall unchanged.
		end
	end

	// A data word enters its FIFO only beside the read status it belongs to.
	a_rsd_with_read: assert property (@(posedge clk) disable iff (!nrst)
		o_rsd_push |-> o_rss_push && o_rss_wdata[vxe_hub_pkg::RNW_BIT]);

	// A master that was just served gives way when the other one is waiting.
	a_m0_yields: assert property (@(posedge clk) disable iff (!nrst)
		o_m0_rss_rd && i_m1_rss_vld |=> !o_m0_rss_rd);
	a_m1_yields: assert property (@(posedge clk) disable iff (!nrst)
		o_m1_rss_rd && i_m0_rss_vld |=> !o_m1_rss_rd);

endmodule

`default_nettype wire

// ==== rsp_fifo.sv ====
// Synchronous FIFO with a registered write and a combinational head read.
// Pushing when full or popping when empty is not allowed and is not guarded in logic.
`timescale 1ns/1ps
`default_nettype none

module rsp_fifo
#(
	parameter int WIDTH = 8		// Word width.
)
(
	input wire			clk,
	input wire			nrst,
	input wire			i_push,		// Write strobe.
	input wire [WIDTH-1:0]		i_wdata,	// Word to write.
	input wire			i_pop,		// Read strobe, takes the head.
	output logic [WIDTH-1:0]	o_rdata,	// Current head word.
	output logic			o_empty,	// No entry holds a word.
	output logic			o_full,		// All entries hold a word.
	output logic			o_afull		// Exactly one entry is free.
);

	// --------------------------------------------------
	// Storage and pointers
	// --------------------------------------------------

	logic [WIDTH-1:0]		mem [vxe_hub_pkg::FIFO_DEPTH];	// Entry array.
	logic [vxe_hub_pkg::FIFO_AW:0]	wp;				// Write pointer with wrap bit.
	logic [vxe_hub_pkg::FIFO_AW:0]	rp;				// Read pointer with wrap bit.
	logic [vxe_hub_pkg::FIFO_AW:0]	fill;				// Number of stored words.

	// Pointers advance on their strobes. Both may move in the same edge.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wp <= '0;
			rp <= '0;
		end
		else
		begin
			if (i_push)
				wp <= wp + 1'b1;
			if (i_pop)
				rp <= rp + 1'b1;
		end
	end

	// The entry array is written on push. A pushed word is at the head one edge later.
	always_ff @(posedge clk)
	begin
		if (i_push)
			mem[wp[vxe_hub_pkg::FIFO_AW-1:0]] <= i_wdata;
	end

	assign o_rdata = mem[rp[vxe_hub_pkg::FIFO_AW-1:0]];	// Head is read without delay.

	// The difference of the wrapped pointers is the fill level.
	assign fill = wp - rp;

	// Same index with equal wrap bits is empty. Different wrap bits is full.
	assign o_empty = (wp == rp);
	assign o_full = (wp[vxe_hub_pkg::FIFO_AW-1:0] == rp[vxe_hub_pkg::FIFO_AW-1:0]) &&
		(wp[vxe_hub_pkg::FIFO_AW] != rp[vxe_hub_pkg::FIFO_AW]);

	// Almost full leaves room for exactly one more word.
	assign o_afull = (fill == (vxe_hub_pkg::FIFO_AW + 1)'(vxe_hub_pkg::FIFO_DEPTH - 1));

	// The writer must have honoured the full flag.
	a_no_push_full: assert property (@(posedge clk) disable iff (!nrst)
		i_push |-> !o_full);

	// The reader must have honoured the empty flag.
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!nrst)
		i_pop |-> !o_empty);

endmodule

`default_nettype wire

// ==== vxe_hub_pkg.sv ====
// Shared definitions of the VPU downstream hub. The status layout is fixed at 9 bits.
// FIFO_DEPTH must stay a power of two, since the pointers wrap through an extra bit.
`default_nettype none

package vxe_hub_pkg;

	// --------------------------------------------------
	// Status word layout
	// --------------------------------------------------

	// The fields are chained from bit 0 upward, so moving one field moves the rest.
	localparam int ERR_LSB = 0;			// Error code, low bit.
	localparam int ERR_MSB = ERR_LSB + 1;		// Error code, high bit.
	localparam int RNW_BIT = ERR_MSB + 1;		// Read-not-write flag.
	localparam int TXNID_LSB = RNW_BIT + 1;		// Transaction id, low bit.
	localparam int TXNID_MSB = TXNID_LSB + 5;	// Transaction id is 6 bits wide.

	// Status word width follows from the top field.
	localparam int RSS_W = TXNID_MSB + 1;

	// Read data word width. Only reads carry a data word.
	localparam int RSD_W = 64;

	// --------------------------------------------------
	// Response FIFOs
	// --------------------------------------------------

	// Entries per FIFO. The merger keeps one entry free as slack.
	localparam int FIFO_DEPTH = 4;

	// Index width. Pointers carry one more bit for the wrap.
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// --------------------------------------------------
	// State codes
	// --------------------------------------------------

	// Receive merger states.
	localparam logic [1:0] RX_IDLE = 2'b00;		// No grant held.
	localparam logic [1:0] RX_M0 = 2'b01;		// Master 0 is granted.
	localparam logic [1:0] RX_M1 = 2'b10;		// Master 1 is granted.
	localparam logic [1:0] RX_STALL = 2'b11;	// Status FIFO too full to take more.

	// Output drain states.
	localparam logic TX_IDLE = 1'b0;		// Output register is empty.
	localparam logic TX_SEND = 1'b1;		// Output register holds a word for the client.

endpackage

`default_nettype wire
